// ==== verilog/huff_sram_pkg.sv ====
`default_nettype none

package huff_sram_pkg;

    typedef logic [31:0]  word_t;   // one bus data word
    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [6:0]   char_t;
    typedef logic [127:0] path_t;

    // controller phase decides who owns the bus
    typedef enum logic [1:0] {
        IDLE,
        HIST,
        CODEBOOK,
        TRANSLATE
    } phase_e;

    typedef struct packed {
        logic  wr;
        logic  rd;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  valid;
        logic  write;   // high stores the count
        char_t index;
        word_t count;
    } hist_cmd_t;

    typedef struct packed {
        logic  valid;
        char_t index;
        path_t path;
    } cb_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/bus_share.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_share import huff_sram_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire phase_e   phase_i,
    input  wire logic     clear_done_i,
    input  wire bus_req_t clear_req_i,
    input  wire bus_req_t hist_req_i,
    input  wire bus_req_t cb_req_i,
    input  wire bus_req_t trn_req_i,
    input  wire logic     busy_i,
    output logic          wr_en_o,
    output logic          r_en_o,
    output addr_t         addr_o,
    output word_t         wdata_o,
    output logic          clear_xfer_o,
    output logic          hist_xfer_o,
    output logic          cb_xfer_o,
    output logic          trn_xfer_o
);

    logic     busy_q;
    logic     xfer_done;
    bus_req_t sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy_i;
        end
    end

    assign xfer_done = busy_q & ~busy_i;   // busy falling ends a transaction

    always_comb begin
        sel          = '0;
        clear_xfer_o = 1'b0;
        hist_xfer_o  = 1'b0;
        cb_xfer_o    = 1'b0;
        trn_xfer_o   = 1'b0;
        case (phase_i)
            HIST: begin
                // clear engine keeps the bus until its block is zeroed
                if (!clear_done_i) begin
                    sel          = clear_req_i;
                    clear_xfer_o = xfer_done;
                end else begin
                    sel         = hist_req_i;
                    hist_xfer_o = xfer_done;
                end
            end
            CODEBOOK: begin
                sel       = cb_req_i;
                cb_xfer_o = xfer_done;
            end
            TRANSLATE: begin
                sel        = trn_req_i;
                trn_xfer_o = xfer_done;
            end
            default: ;   // idle keeps the bus quiet
        endcase
    end

    assign wr_en_o = sel.wr;
    assign r_en_o  = sel.rd;
    assign addr_o  = sel.addr;
    assign wdata_o = sel.wdata;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(wr_en_o && r_en_o));

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
        (wr_en_o || r_en_o) |-> !busy_i);

endmodule

`default_nettype wire

// ==== verilog/hist_clear.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_clear import huff_sram_pkg::*; #(
    parameter addr_t       HIST_BASE   = 32'h3300_0000,
    parameter int unsigned CLEAR_WORDS = 2048
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire phase_e phase_i,
    input  wire logic   xfer_done_i,
    input  wire logic   busy_i,
    output bus_req_t    req_o,
    output logic        clear_done_o
);

    localparam int CNT_W = $clog2(CLEAR_WORDS + 1);

    typedef enum logic [1:0] {ARMED, ISSUE, WAIT, DONE} state_t;

    state_t           state;
    logic [CNT_W-1:0] word_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ARMED;
            word_cnt <= '0;
        end else begin
            case (state)
                ARMED: begin
                    if (phase_i == HIST) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (!busy_i) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (xfer_done_i) begin
                        if (word_cnt == CNT_W'(CLEAR_WORDS - 1)) begin
                            state <= DONE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= ISSUE;
                        end
                    end
                end
                default: ;   // finished for good
            endcase
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.wr    = (state == ISSUE) && !busy_i;
        req_o.addr  = HIST_BASE + (addr_t'(word_cnt) << 2);
        req_o.wdata = '0;   // zero fill
    end

    assign clear_done_o = (state == DONE);

endmodule

`default_nettype wire

// ==== verilog/hist_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_access import huff_sram_pkg::*; #(
    parameter addr_t HIST_BASE = 32'h3300_0000
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire hist_cmd_t cmd_i,
    input  wire word_t     rdata_i,
    input  wire logic      xfer_done_i,
    input  wire logic      busy_i,
    output bus_req_t       req_o,
    output logic           ack_o,
    output word_t          old_count_o
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;

    state_t state;
    logic   write_q;
    char_t  index_q;
    word_t  count_q;
    word_t  old_q;
    logic   done;

    assign done = (state == WAIT) && xfer_done_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            old_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_i.valid) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (!busy_i) begin
                        state <= WAIT;
                    end
                end
                default: begin
                    if (xfer_done_i) begin
                        state <= IDLE;
                        if (!write_q) begin
                            old_q <= rdata_i;
                        end
                    end
                end
            endcase
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_i.valid) begin
            write_q <= cmd_i.write;
            index_q <= cmd_i.index;
            count_q <= cmd_i.count;
        end
    end

    always_comb begin
        req_o.wr    = (state == ISSUE) && !busy_i && write_q;
        req_o.rd    = (state == ISSUE) && !busy_i && !write_q;
        req_o.addr  = HIST_BASE + (addr_t'(index_q) << 2);
        req_o.wdata = count_q;
    end

    assign ack_o       = done;
    assign old_count_o = (done && !write_q) ? rdata_i : old_q;   // read data valid in ack cycle

    a_cmd_when_idle: assert property (@(posedge clk) disable iff (rst)
        cmd_i.valid |-> state == IDLE);

endmodule

`default_nettype wire

// ==== verilog/codebook_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module codebook_store import huff_sram_pkg::*; #(
    parameter addr_t CODE_BASE = 32'h3300_2000
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire cb_cmd_t cmd_i,
    input  wire logic    xfer_done_i,
    input  wire logic    busy_i,
    output bus_req_t     req_o,
    output logic         done_o
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;

    state_t      state;
    logic [1:0]  word_cnt;
    char_t       index_q;
    word_t [3:0] path_q;   // [3] is path bits 127:96
    logic        last;

    assign last = (word_cnt == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_i.valid) begin
                        word_cnt <= '0;
                        state    <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (!busy_i) begin
                        state <= WAIT;
                    end
                end
                default: begin
                    if (xfer_done_i) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= last ? IDLE : ISSUE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_i.valid) begin
            index_q <= cmd_i.index;
            path_q  <= cmd_i.path;
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.wr    = (state == ISSUE) && !busy_i;
        // 16 bytes per entry with msw first
        req_o.addr  = CODE_BASE + (addr_t'(index_q) << 4) + (addr_t'(word_cnt) << 2);
        req_o.wdata = path_q[2'd3 - word_cnt];
    end

    assign done_o = (state == WAIT) && xfer_done_i && last;

endmodule

`default_nettype wire

// ==== verilog/path_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module path_fetch import huff_sram_pkg::*; #(
    parameter addr_t CODE_BASE = 32'h3300_2000
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start_i,
    input  wire char_t index_i,
    input  wire word_t rdata_i,
    input  wire logic  xfer_done_i,
    input  wire logic  busy_i,
    output bus_req_t   req_o,
    output logic       path_valid_o,
    output path_t      path_o
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;

    state_t     state;
    logic [1:0] word_cnt;
    char_t      index_q;
    logic       last;

    assign last = (word_cnt == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            word_cnt     <= '0;
            path_valid_o <= 1'b0;
            path_o       <= '0;
        end else begin
            path_valid_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        word_cnt <= '0;
                        state    <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (!busy_i) begin
                        state <= WAIT;
                    end
                end
                default: begin
                    if (xfer_done_i) begin
                        // first word read ends up in the top bits
                        path_o       <= {path_o[95:0], rdata_i};
                        word_cnt     <= word_cnt + 1'b1;
                        path_valid_o <= last;
                        state        <= last ? IDLE : ISSUE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            index_q <= index_i;
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.rd    = (state == ISSUE) && !busy_i;
        req_o.addr  = CODE_BASE + (addr_t'(index_q) << 4) + (addr_t'(word_cnt) << 2);
    end

endmodule

`default_nettype wire

// ==== verilog/huff_sram_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module huff_sram_if import huff_sram_pkg::*; #(
    parameter addr_t       HIST_BASE   = 32'h3300_0000,
    parameter addr_t       CODE_BASE   = 32'h3300_2000,
    parameter int unsigned CLEAR_WORDS = 2048
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire phase_e    phase_i,
    input  wire hist_cmd_t hist_cmd_i,
    input  wire cb_cmd_t   cb_cmd_i,
    input  wire logic      trn_valid_i,
    input  wire char_t     trn_index_i,
    input  wire logic      busy_i,
    input  wire word_t     rdata_i,
    output logic           wr_en_o,
    output logic           r_en_o,
    output addr_t          addr_o,
    output word_t          wdata_o,
    output logic           clear_done_o,
    output logic           hist_ack_o,
    output word_t          old_count_o,
    output logic           cb_done_o,
    output logic           path_valid_o,
    output path_t          path_o
);

    bus_req_t clear_req;
    bus_req_t hist_req;
    bus_req_t cb_req;
    bus_req_t trn_req;
    logic     clear_xfer;
    logic     hist_xfer;
    logic     cb_xfer;
    logic     trn_xfer;

    bus_share u_bus_share (
        .clk          (clk),
        .rst          (rst),
        .phase_i      (phase_i),
        .clear_done_i (clear_done_o),
        .clear_req_i  (clear_req),
        .hist_req_i   (hist_req),
        .cb_req_i     (cb_req),
        .trn_req_i    (trn_req),
        .busy_i       (busy_i),
        .wr_en_o      (wr_en_o),
        .r_en_o       (r_en_o),
        .addr_o       (addr_o),
        .wdata_o      (wdata_o),
        .clear_xfer_o (clear_xfer),
        .hist_xfer_o  (hist_xfer),
        .cb_xfer_o    (cb_xfer),
        .trn_xfer_o   (trn_xfer)
    );

    hist_clear #(
        .HIST_BASE   (HIST_BASE),
        .CLEAR_WORDS (CLEAR_WORDS)
    ) u_hist_clear (
        .clk          (clk),
        .rst          (rst),
        .phase_i      (phase_i),
        .xfer_done_i  (clear_xfer),
        .busy_i       (busy_i),
        .req_o        (clear_req),
        .clear_done_o (clear_done_o)
    );

    hist_access #(
        .HIST_BASE (HIST_BASE)
    ) u_hist_access (
        .clk         (clk),
        .rst         (rst),
        .cmd_i       (hist_cmd_i),
        .rdata_i     (rdata_i),
        .xfer_done_i (hist_xfer),
        .busy_i      (busy_i),
        .req_o       (hist_req),
        .ack_o       (hist_ack_o),
        .old_count_o (old_count_o)
    );

    codebook_store #(
        .CODE_BASE (CODE_BASE)
    ) u_codebook_store (
        .clk         (clk),
        .rst         (rst),
        .cmd_i       (cb_cmd_i),
        .xfer_done_i (cb_xfer),
        .busy_i      (busy_i),
        .req_o       (cb_req),
        .done_o      (cb_done_o)
    );

    path_fetch #(
        .CODE_BASE (CODE_BASE)
    ) u_path_fetch (
        .clk          (clk),
        .rst          (rst),
        .start_i      (trn_valid_i),
        .index_i      (trn_index_i),
        .rdata_i      (rdata_i),
        .xfer_done_i  (trn_xfer),
        .busy_i       (busy_i),
        .req_o        (trn_req),
        .path_valid_o (path_valid_o),
        .path_o       (path_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/tb_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram import huff_sram_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       wr_en_i,
    input  wire logic       r_en_i,
    input  wire addr_t      addr_i,
    input  wire word_t      wdata_i,
    input  wire logic [1:0] hold_len_i,
    input  wire addr_t      peek_addr_i,
    output logic            busy_o,
    output word_t           rdata_o,
    output word_t           peek_data_o
);

    word_t       mem [0:4095];   // word addressed by addr[13:2]
    logic [1:0]  hold_cnt;
    logic [11:0] rd_idx;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_o   <= 1'b0;
            rdata_o  <= '0;
            hold_cnt <= 2'd0;
            rd_idx   <= '0;
            for (int i = 0; i < 4096; i++) begin
                mem[12'(i)] <= '1;   // erased state
            end
        end else if (hold_cnt != 2'd0) begin
            hold_cnt <= hold_cnt - 2'd1;
            if (hold_cnt == 2'd1) begin
                busy_o  <= 1'b0;
                rdata_o <= mem[rd_idx];   // valid in the end cycle
            end
        end else if (wr_en_i || r_en_i) begin
            busy_o   <= 1'b1;
            hold_cnt <= hold_len_i;
            rd_idx   <= addr_i[13:2];
            if (wr_en_i) begin
                mem[addr_i[13:2]] <= wdata_i;
            end
        end
    end

    assign peek_data_o = mem[peek_addr_i[13:2]];   // backdoor for the checker

endmodule

`default_nettype wire

// ==== sim/tb_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_check import huff_sram_pkg::*; #(
    parameter addr_t       HIST_BASE   = 32'h0000_1000,
    parameter addr_t       CODE_BASE   = 32'h0000_2000,
    parameter int unsigned CLEAR_WORDS = 16
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire phase_e    phase_i,
    input  wire hist_cmd_t hist_cmd_i,
    input  wire cb_cmd_t   cb_cmd_i,
    input  wire logic      trn_valid_i,
    input  wire char_t     trn_index_i,
    input  wire logic      busy_i,
    input  wire logic      wr_en_i,
    input  wire logic      r_en_i,
    input  wire addr_t     addr_i,
    input  wire logic      clear_done_i,
    input  wire logic      hist_ack_i,
    input  wire word_t     old_count_i,
    input  wire logic      cb_done_i,
    input  wire logic      path_valid_i,
    input  wire path_t     path_i,
    input  wire word_t     peek_data_i,
    output addr_t          peek_addr_o,
    output int             value_errs_o,
    output int             proto_errs_o,
    output int             checks_o
);

    word_t hist_model [0:127];
    path_t path_model [0:127];
    logic  pend_write;
    char_t pend_hist_idx;
    char_t pend_cb_idx;
    char_t pend_trn_idx;
    logic  any_hist_write;
    logic  clear_seen;

    function automatic logic in_region(input addr_t a, input addr_t base, input addr_t size);
        return (a >= base) && (a < base + size);
    endfunction

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
        value_errs_o++;
        $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    endtask

    // four words straight out of the memory model
    task automatic check_codebook(input char_t index);
        word_t exp;
        for (int k = 0; k < 4; k++) begin
            peek_addr_o = CODE_BASE + (addr_t'(index) << 4) + addr_t'(4 * k);
            #1;
            exp = word_t'(path_model[index] >> (96 - 32 * k));   // msw first
            if (peek_data_i !== exp) begin
                report_value("codebook", 128'(exp), 128'(peek_data_i));
            end
        end
    endtask

    initial begin : results
        value_errs_o   = 0;
        checks_o       = 0;
        peek_addr_o    = CODE_BASE;
        pend_write     = 1'b0;
        pend_hist_idx  = '0;
        pend_cb_idx    = '0;
        pend_trn_idx   = '0;
        any_hist_write = 1'b0;
        clear_seen     = 1'b0;
        for (int i = 0; i < 128; i++) begin
            hist_model[7'(i)] = '1;
            path_model[7'(i)] = '1;
        end
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (clear_done_i && !clear_seen) begin
                    clear_seen = 1'b1;
                    for (int i = 0; i < int'(CLEAR_WORDS) && i < 128; i++) begin
                        hist_model[7'(i)] = '0;
                    end
                end
                if (hist_cmd_i.valid) begin
                    pend_write    = hist_cmd_i.write;
                    pend_hist_idx = hist_cmd_i.index;
                    if (hist_cmd_i.write) begin
                        hist_model[hist_cmd_i.index] = hist_cmd_i.count;
                        any_hist_write               = 1'b1;
                    end
                end
                if (hist_ack_i && !pend_write) begin
                    checks_o++;
                    if (old_count_i !== hist_model[pend_hist_idx]) begin
                        report_value(any_hist_write ? "hist" : "clear",
                                     128'(hist_model[pend_hist_idx]), 128'(old_count_i));
                    end
                end
                if (cb_cmd_i.valid) begin
                    pend_cb_idx             = cb_cmd_i.index;
                    path_model[cb_cmd_i.index] = cb_cmd_i.path;
                end
                if (trn_valid_i) begin
                    pend_trn_idx = trn_index_i;
                end
                if (path_valid_i) begin
                    checks_o++;
                    if (path_i !== path_model[pend_trn_idx]) begin
                        report_value("fetch", path_model[pend_trn_idx], path_i);
                    end
                end
                if (cb_done_i) begin
                    checks_o++;
                    check_codebook(pend_cb_idx);
                end
            end
        end
    end

    initial begin : protocol
        proto_errs_o = 0;
        forever begin
            @(negedge clk);
            if (!rst && (wr_en_i || r_en_i)) begin
                if (busy_i) begin
                    proto_errs_o++;
                    $display("Strobe issued while the SRAM was busy, addr %h", addr_i);
                end
                case (phase_i)
                    IDLE: begin
                        proto_errs_o++;
                        $display("Strobe issued in the idle phase, addr %h", addr_i);
                    end
                    HIST: begin
                        if (!in_region(addr_i, HIST_BASE, 32'd512)) begin
                            proto_errs_o++;
                            $display("Address %h lies outside the histogram", addr_i);
                        end
                    end
                    default: begin
                        if (!in_region(addr_i, CODE_BASE, 32'd2048)) begin
                            proto_errs_o++;
                            $display("Address %h lies outside the codebook", addr_i);
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import huff_sram_pkg::*; ();

    localparam addr_t HIST_BASE   = 32'h0000_1000;
    localparam addr_t CODE_BASE   = 32'h0000_2000;
    localparam int    CLEAR_WORDS = 16;
    localparam int    N_HIST      = 12;
    localparam int    N_CB        = 8;
    localparam char_t BLANK_IDX   = 7'd100;   // never written in the codebook
    localparam int    N_TXN       = CLEAR_WORDS + 16 + 2 * N_HIST + 4 * N_CB + 4 * (N_CB + 1);
    localparam int    LIMIT       = 40 * N_TXN;
    localparam int    N_CHECKS    = 16 + N_HIST + N_CB + N_CB + 1;

    logic        clk;
    logic        rst;
    phase_e      phase;
    hist_cmd_t   hist_cmd;
    cb_cmd_t     cb_cmd;
    logic        trn_valid;
    char_t       trn_index;
    logic        busy;
    word_t       rdata;
    logic        wr_en;
    logic        r_en;
    addr_t       addr;
    word_t       wdata;
    logic        clear_done;
    logic        hist_ack;
    word_t       old_count;
    logic        cb_done;
    logic        path_valid;
    path_t       path;
    logic [1:0]  hold_len;
    addr_t       peek_addr;
    word_t       peek_data;
    int          value_errs;
    int          proto_errs;
    int          checks;
    logic [31:0] lfsr_state;
    char_t       hist_idx_q [$];
    char_t       cb_idx_q [$];

    tb_clk u_clk (
        .clk (clk),
        .rst (rst)
    );

    huff_sram_if #(
        .HIST_BASE   (HIST_BASE),
        .CODE_BASE   (CODE_BASE),
        .CLEAR_WORDS (CLEAR_WORDS)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .phase_i      (phase),
        .hist_cmd_i   (hist_cmd),
        .cb_cmd_i     (cb_cmd),
        .trn_valid_i  (trn_valid),
        .trn_index_i  (trn_index),
        .busy_i       (busy),
        .rdata_i      (rdata),
        .wr_en_o      (wr_en),
        .r_en_o       (r_en),
        .addr_o       (addr),
        .wdata_o      (wdata),
        .clear_done_o (clear_done),
        .hist_ack_o   (hist_ack),
        .old_count_o  (old_count),
        .cb_done_o    (cb_done),
        .path_valid_o (path_valid),
        .path_o       (path)
    );

    tb_sram u_sram (
        .clk         (clk),
        .rst         (rst),
        .wr_en_i     (wr_en),
        .r_en_i      (r_en),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .hold_len_i  (hold_len),
        .peek_addr_i (peek_addr),
        .busy_o      (busy),
        .rdata_o     (rdata),
        .peek_data_o (peek_data)
    );

    tb_check #(
        .HIST_BASE   (HIST_BASE),
        .CODE_BASE   (CODE_BASE),
        .CLEAR_WORDS (CLEAR_WORDS)
    ) u_check (
        .clk          (clk),
        .rst          (rst),
        .phase_i      (phase),
        .hist_cmd_i   (hist_cmd),
        .cb_cmd_i     (cb_cmd),
        .trn_valid_i  (trn_valid),
        .trn_index_i  (trn_index),
        .busy_i       (busy),
        .wr_en_i      (wr_en),
        .r_en_i       (r_en),
        .addr_i       (addr),
        .clear_done_i (clear_done),
        .hist_ack_i   (hist_ack),
        .old_count_i  (old_count),
        .cb_done_i    (cb_done),
        .path_valid_i (path_valid),
        .path_i       (path),
        .peek_data_i  (peek_data),
        .peek_addr_o  (peek_addr),
        .value_errs_o (value_errs),
        .proto_errs_o (proto_errs),
        .checks_o     (checks)
    );

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [127:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[126:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // one clock with inputs changing 1 ns after the edge
    task automatic tick();
        logic [127:0] r;
        @(posedge clk);
        #1;
        take_bits(2, r);
        hold_len = (r[1:0] == 2'd0) ? 2'd1 : r[1:0];   // busy for 1..3 cycles
    endtask

    task automatic hist_op(input logic write, input char_t index, input word_t count);
        hist_cmd.valid = 1'b1;
        hist_cmd.write = write;
        hist_cmd.index = index;
        hist_cmd.count = count;
        tick();
        hist_cmd = '0;
        while (!hist_ack) tick();
        tick();
    endtask

    task automatic cb_write(input char_t index, input path_t code);
        cb_cmd.valid = 1'b1;
        cb_cmd.index = index;
        cb_cmd.path  = code;
        tick();
        cb_cmd = '0;
        while (!cb_done) tick();
        tick();
    endtask

    task automatic fetch(input char_t index);
        trn_valid = 1'b1;
        trn_index = index;
        tick();
        trn_valid = 1'b0;
        while (!path_valid) tick();
        tick();
    endtask

    initial begin : stimulus
        logic [127:0] r;
        char_t        idx;
        int           fails;
        phase      = IDLE;
        hist_cmd   = '0;
        cb_cmd     = '0;
        trn_valid  = 1'b0;
        trn_index  = '0;
        hold_len   = 2'd1;
        lfsr_state = 32'd66679;
        wait (rst == 1'b0);
        tick();

        phase = HIST;
        while (!clear_done) tick();
        tick();
        for (int i = 0; i < 16; i++) begin
            hist_op(1'b0, char_t'(i), '0);   // zeroed block reads back
        end
        for (int i = 0; i < N_HIST; i++) begin
            take_bits(4, r);
            idx = {3'b000, r[3:0]};
            take_bits(32, r);
            hist_op(1'b1, idx, r[31:0]);
            hist_idx_q.push_back(idx);
        end
        foreach (hist_idx_q[i]) begin
            hist_op(1'b0, hist_idx_q[i], '0);
        end

        phase = CODEBOOK;
        tick();
        for (int i = 0; i < N_CB; i++) begin
            take_bits(6, r);
            idx = {1'b0, r[5:0]};
            take_bits(128, r);
            cb_write(idx, r);
            cb_idx_q.push_back(idx);
        end

        phase = TRANSLATE;
        tick();
        foreach (cb_idx_q[i]) begin
            fetch(cb_idx_q[i]);
        end
        fetch(BLANK_IDX);

        phase = IDLE;
        repeat (4) tick();
        fails = value_errs + proto_errs;
        if (checks != N_CHECKS) begin
            $display("Ran %0d result checks where %0d were expected", checks, N_CHECKS);
            fails++;
        end
        $display("value errors %0d, protocol errors %0d, checks run %0d",
                 value_errs, proto_errs, checks);
        if (fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a transaction never completed", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== huff_sram_if.f ====
verilog/huff_sram_pkg.sv
verilog/bus_share.sv
verilog/hist_clear.sv
verilog/hist_access.sv
verilog/codebook_store.sv
verilog/path_fetch.sv
verilog/huff_sram_if.sv
sim/tb_clk.sv
sim/tb_sram.sv
sim/tb_check.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_top -f huff_sram_if.f -o sim_tb \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0
